/* design/fmap_pkg.sv */
package fmap_pkg;

    // widths
    localparam int stage_w    = 6;  // stage number from the accelerator
    localparam int coord_w    = 4;  // x, y and map count
    localparam int offset_y_w = 6;  // row offset reaches 48 in the 16x16 layers
    localparam int addr_w     = 11; // feature-map RAM word address

    // bank geometry
    localparam int bank_count = 8;  // AC0..AC3 then B0..B3
    localparam int ac_pitch   = 17; // words per row, AC banks
    localparam int b_pitch    = 16; // words per row, B banks

    localparam int last_stage = 11; // 16x16 and 8x8 layers only

    // which banks a stage writes into
    typedef enum logic [1:0] {
        bank_none,
        bank_b_rotate, // one B bank, picked by map count mod 4
        bank_ac_all,
        bank_b_all
    } bank_kind_e;

    // raster position inside the current stage
    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        logic [coord_w-1:0] map_count; // finished maps, wraps at 16
    } fmap_pos_t;

    // placement of the current map inside the bank
    typedef struct packed {
        logic [coord_w-1:0]    ox;
        logic [offset_y_w-1:0] oy;
    } fmap_offset_t;

    // per-stage geometry
    typedef struct packed {
        logic [coord_w-1:0] size; // last coordinate of the square map
        bank_kind_e         kind;
    } stage_info_t;

endpackage

/* design/fmap_stage_decode.sv */
module fmap_stage_decode
    import fmap_pkg::*;
(
    input  logic [stage_w-1:0] stage,
    output stage_info_t        info
);

    logic supported;

    // stage 0 is idle, stages past the 8x8 layers are not handled here
    assign supported = (stage != '0) && (stage <= last_stage);

    always_comb begin
        info.size = '0;
        info.kind = bank_none;
        if (supported) begin
            case (stage)
                6'd1, 6'd3, 6'd11: begin
                    info.size = 4'd15; // 16x16 maps
                end
                default: begin
                    info.size = 4'd7;  // 8x8 maps
                end
            endcase

            case (stage)
                6'd1: begin
                    info.kind = bank_b_rotate;
                end
                6'd4, 6'd7, 6'd9, 6'd10: begin
                    info.kind = bank_b_all;
                end
                6'd2, 6'd3, 6'd5, 6'd6, 6'd8: begin
                    info.kind = bank_ac_all;
                end
                default: begin
                    info.kind = bank_none;
                end
            endcase
        end
    end

endmodule

/* design/fmap_position_counter.sv */
module fmap_position_counter
    import fmap_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [stage_w-1:0] stage,
    input  logic               write,
    input  stage_info_t        info,
    output fmap_pos_t          pos
);

    logic [stage_w-1:0] stage_record; // stage the raster belongs to
    logic               x_last;
    logic               y_last;
    logic               stage_changed;

    assign x_last        = (pos.x == info.size);
    assign y_last        = (pos.y == info.size);
    assign stage_changed = (stage != stage_record);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pos          <= '0;
            stage_record <= '0;
        end else if (write) begin
            if (x_last && y_last) begin
                pos.x         <= '0;
                pos.y         <= '0;
                pos.map_count <= pos.map_count + 1'b1; // map done
            end else if (x_last) begin
                pos.x <= '0;
                pos.y <= pos.y + 1'b1;
            end else begin
                pos.x <= pos.x + 1'b1;
            end
        end else if (stage_changed) begin
            // new stage starts at the first map, top left corner
            pos          <= '0;
            stage_record <= stage;
        end
    end

endmodule

/* design/fmap_offset_table.sv */
module fmap_offset_table
    import fmap_pkg::*;
(
    input  logic [stage_w-1:0] stage,
    input  logic [coord_w-1:0] map_count,
    output fmap_offset_t       offset
);

    always_comb begin
        offset = '0; // unlisted stage or count sits at (0,0)
        case (stage)
            6'd1: begin
                offset.oy = {map_count[3:2], 4'b0000}; // new 16-row band every 4 maps
            end
            6'd2, 6'd9: begin
                case (map_count)
                    4'd1: offset = '{ox: 4'd8, oy: 6'd0};
                    4'd2: offset = '{ox: 4'd0, oy: 6'd8};
                    4'd3: offset = '{ox: 4'd8, oy: 6'd8};
                    default: offset = '0;
                endcase
            end
            6'd3: begin
                case (map_count)
                    4'd0: offset = '{ox: 4'd0, oy: 6'd16};
                    4'd1: offset = '{ox: 4'd0, oy: 6'd32};
                    default: offset = '0;
                endcase
            end
            6'd4, 6'd7: begin
                case (map_count)
                    4'd1: offset = '{ox: 4'd8, oy: 6'd0};
                    default: offset = '0;
                endcase
            end
            6'd5: begin
                case (map_count)
                    4'd0: offset = '{ox: 4'd0, oy: 6'd16};
                    4'd1: offset = '{ox: 4'd8, oy: 6'd16};
                    default: offset = '0;
                endcase
            end
            6'd6: begin
                case (map_count)
                    4'd0: offset = '{ox: 4'd0, oy: 6'd24};
                    4'd1: offset = '{ox: 4'd8, oy: 6'd24};
                    default: offset = '0;
                endcase
            end
            6'd8: begin
                case (map_count)
                    4'd0: offset = '{ox: 4'd0, oy: 6'd32};
                    4'd1: offset = '{ox: 4'd8, oy: 6'd32};
                    default: offset = '0;
                endcase
            end
            6'd10: begin
                // 2x2 tiles below the stage 9 block
                case (map_count)
                    4'd0: offset = '{ox: 4'd0, oy: 6'd16};
                    4'd1: offset = '{ox: 4'd8, oy: 6'd16};
                    4'd2: offset = '{ox: 4'd0, oy: 6'd24};
                    4'd3: offset = '{ox: 4'd8, oy: 6'd24};
                    default: offset = '0;
                endcase
            end
            6'd11: begin
                case (map_count)
                    4'd0: offset = '{ox: 4'd0, oy: 6'd32};
                    4'd1: offset = '{ox: 4'd0, oy: 6'd48};
                    default: offset = '0;
                endcase
            end
            default: begin
                offset = '0;
            end
        endcase
    end

endmodule

/* design/fmap_addr_gen.sv */
module fmap_addr_gen
    import fmap_pkg::*;
(
    input  logic                  reset,
    input  logic                  write,
    input  stage_info_t           info,
    input  fmap_pos_t             pos,
    input  fmap_offset_t          offset,
    output logic [addr_w-1:0]     write_addr,
    output logic [bank_count-1:0] write_enable
);

    logic [addr_w-1:0] row;   // y inside the bank
    logic [addr_w-1:0] col;   // x inside the bank
    logic [addr_w-1:0] pitch;

    assign row   = addr_w'(pos.y) + addr_w'(offset.oy);
    assign col   = addr_w'(pos.x) + addr_w'(offset.ox);
    assign pitch = (info.kind == bank_ac_all) ? addr_w'(ac_pitch) : addr_w'(b_pitch);

    always_comb begin
        write_enable = '0;
        if (reset && write) begin
            case (info.kind)
                bank_b_rotate: begin
                    write_enable[{1'b1, pos.map_count[1:0]}] = 1'b1; // B0..B3 in turn
                end
                bank_ac_all: begin
                    write_enable[bank_count/2-1:0] = '1;
                end
                bank_b_all: begin
                    write_enable[bank_count-1:bank_count/2] = '1;
                end
                default: begin
                    write_enable = '0;
                end
            endcase
        end
    end

    // address only means something while a bank is written
    assign write_addr = (write_enable != '0) ? (row * pitch + col) : '0;

endmodule

/* design/fmap_write_ctrl.sv */
module fmap_write_ctrl
    import fmap_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [stage_w-1:0]    stage,
    input  logic                  write,
    output logic [addr_w-1:0]     write_addr,
    output logic [bank_count-1:0] write_enable
);

    stage_info_t  info;
    fmap_pos_t    pos;
    fmap_offset_t offset;

    fmap_stage_decode u_stage_decode (
        .stage (stage),
        .info  (info)
    );

    fmap_position_counter u_position_counter (
        .clk   (clk),
        .reset (reset),
        .stage (stage),
        .write (write),
        .info  (info),
        .pos   (pos)
    );

    // looked up from the live count, no extra cycle
    fmap_offset_table u_offset_table (
        .stage     (stage),
        .map_count (pos.map_count),
        .offset    (offset)
    );

    fmap_addr_gen u_addr_gen (
        .reset        (reset),
        .write        (write),
        .info         (info),
        .pos          (pos),
        .offset       (offset),
        .write_addr   (write_addr),
        .write_enable (write_enable)
    );

endmodule

/* tests/fmap_model.svh */
`ifndef FMAP_MODEL_SVH
`define FMAP_MODEL_SVH

int model_x;     // column of the next word
int model_y;     // row of the next word
int model_count; // finished maps, mod 16
int model_stage; // stage the raster belongs to

function automatic int map_last_coord(input int s);
    case (s)
        1, 3, 11: return 15;
        2, 4, 5, 6, 7, 8, 9, 10: return 7;
        default: return 0;
    endcase
endfunction

function automatic bank_kind_e bank_kind_of(input int s);
    case (s)
        1: return bank_b_rotate;
        4, 7, 9, 10: return bank_b_all;
        2, 3, 5, 6, 8: return bank_ac_all;
        default: return bank_none;
    endcase
endfunction

function automatic int row_offset(input int s, input int c);
    case (s)
        1: return 16 * (c / 4); // one band of 16 rows per four maps
        2, 9: return (c == 2 || c == 3) ? 8 : 0;
        3: return (c == 0) ? 16 : ((c == 1) ? 32 : 0);
        5: return (c < 2) ? 16 : 0;
        6: return (c < 2) ? 24 : 0;
        8: return (c < 2) ? 32 : 0;
        10: return (c < 2) ? 16 : ((c < 4) ? 24 : 0);
        11: return (c == 0) ? 32 : ((c == 1) ? 48 : 0);
        default: return 0;
    endcase
endfunction

function automatic int column_offset(input int s, input int c);
    case (s)
        2, 9, 10: return (c == 1 || c == 3) ? 8 : 0;
        4, 5, 6, 7, 8: return (c == 1) ? 8 : 0;
        default: return 0;
    endcase
endfunction

function automatic int expected_enable(input int s, input logic w, input int c);
    if (!w) begin
        return 0;
    end
    case (bank_kind_of(s))
        bank_b_rotate: return 16 << (c % 4); // B0 is bit 4
        bank_ac_all: return 'h0f;
        bank_b_all: return 'hf0;
        default: return 0;
    endcase
endfunction

function automatic int expected_address(input int s, input logic w, input int x,
                                        input int y, input int c);
    int pitch;
    if (expected_enable(s, w, c) == 0) begin
        return 0;
    end
    pitch = (bank_kind_of(s) == bank_ac_all) ? 17 : 16;
    return ((y + row_offset(s, c)) * pitch + x + column_offset(s, c)) % 2048;
endfunction

// state after the coming rising edge
task automatic advance_model(input logic rst, input int s, input logic w);
    int last;
    last = map_last_coord(s);
    if (!rst) begin
        model_x     = 0;
        model_y     = 0;
        model_count = 0;
        model_stage = 0;
    end else if (w) begin
        if (model_x == last && model_y == last) begin
            model_x     = 0;
            model_y     = 0;
            model_count = (model_count + 1) % 16;
        end else if (model_x == last) begin
            model_x = 0;
            model_y = (model_y + 1) % 16;
        end else begin
            model_x = (model_x + 1) % 16; // may run past a smaller map after a stage change
        end
    end else if (s != model_stage) begin
        model_x     = 0;
        model_y     = 0;
        model_count = 0;
        model_stage = s;
    end
endtask

`endif

/* tests/tb_fmap_write_ctrl.sv */
module tb_fmap_write_ctrl
    import fmap_pkg::*;
;

    logic                  clk;
    logic                  reset;
    logic [stage_w-1:0]    stage;
    logic                  write;
    logic [addr_w-1:0]     write_addr;
    logic [bank_count-1:0] write_enable;

    logic hold_reset;   // keeps reset low at each drive point
    int   sampled_addr; // write_addr seen in the last cycle
    int   error_count;
    int   ac_stages[5];
    int   ac_maps[5];

    `include "fmap_model.svh"

    fmap_write_ctrl u_fmap_write_ctrl (
        .clk          (clk),
        .reset        (reset),
        .stage        (stage),
        .write        (write),
        .write_addr   (write_addr),
        .write_enable (write_enable)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_value(input string test_name, input string what,
                               input int expected, input int actual);
        assert (actual == expected) else begin
            error_count++;
            $display("Mismatch %s %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            $display("TB FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // one clock: drive after the edge, sample just before the next one
    task automatic run_cycle(input int s, input logic w, input string test_name);
        int exp_en;
        int exp_addr;
        @(posedge clk);
        #2;
        reset = !hold_reset;
        stage = 6'(s);
        write = w;
        #15;
        if (hold_reset) begin
            exp_en   = 0;
            exp_addr = 0;
        end else begin
            exp_en   = expected_enable(s, w, model_count);
            exp_addr = expected_address(s, w, model_x, model_y, model_count);
        end
        check_value(test_name, "write_enable", exp_en, int'(write_enable));
        check_value(test_name, "write_addr", exp_addr, int'(write_addr));
        sampled_addr = int'(write_addr);
        advance_model(reset, s, w);
    endtask

    // write words until the given number of maps is complete
    task automatic run_maps(input int s, input int maps, input string test_name);
        int target;
        int cycles;
        int limit;
        target = (model_count + maps) % 16;
        limit  = maps * 256 + 16;
        cycles = 0;
        do begin
            run_cycle(s, 1'b1, test_name);
            cycles++;
        end while (model_count != target && cycles < limit);
        if (model_count != target) begin
            $display("timeout in %s: stage %0d did not finish %0d maps in %0d cycles",
                     test_name, s, maps, limit);
            $display("TB FAILED");
            $fatal(1, "map count never reached its target");
        end
    endtask

    initial begin
        int i;
        int j;
        int gap;
        int hold_addr;
        int s;
        int len;
        logic w;
        reset        = 1'b0;
        stage        = '0;
        write        = 1'b0;
        hold_reset   = 1'b1;
        sampled_addr = 0;
        error_count  = 0;
        ac_stages    = '{2, 3, 5, 6, 8};
        ac_maps      = '{4, 2, 2, 2, 2};
        advance_model(1'b0, 0, 1'b0);
        void'($urandom(32'h10012ec0));

        // idle and unsupported stages, enable stays low in reset
        for (i = 0; i < 10; i++) begin
            run_cycle(i + 1, 1'b1, "reset"); // stages that would write outside reset
        end
        hold_reset = 1'b0;
        for (i = 0; i < 20; i++) begin
            run_cycle(0, 1'b1, "idle stage");
        end
        for (i = 0; i < 40; i++) begin
            run_cycle(int'($urandom_range(63, 12)), 1'b1, "unsupported stage");
        end

        // 16 maps of 16x16 rotating over the B banks
        run_cycle(1, 1'b0, "stage 1 walk");
        run_maps(1, 16, "stage 1 walk");

        for (i = 0; i < 5; i++) begin
            run_cycle(ac_stages[i], 1'b0, "ac stages");
            run_maps(ac_stages[i], ac_maps[i], "ac stages");
        end

        // gaps with write low keep the raster where it was
        run_cycle(5, 1'b0, "restart");
        for (i = 0; i < 11; i++) begin
            run_cycle(5, 1'b1, "restart");
        end
        for (j = 0; j < 4; j++) begin
            hold_addr = expected_address(5, 1'b1, model_x, model_y, model_count);
            gap = int'($urandom_range(12, 1));
            for (i = 0; i < gap; i++) begin
                run_cycle(5, 1'b0, "hold");
            end
            run_cycle(5, 1'b1, "hold");
            check_value("hold", "address after gap", hold_addr, sampled_addr);
        end

        run_cycle(6, 1'b0, "restart");
        run_cycle(6, 1'b1, "restart");
        check_value("restart", "first address of stage 6", 24 * 17, sampled_addr);
        for (i = 0; i < 5; i++) begin
            run_cycle(6, 1'b1, "restart");
        end

        // x = 6 carries over into stage 8 map 0
        run_cycle(8, 1'b1, "stage change during write");
        check_value("stage change during write", "no restart", 32 * 17 + 6, sampled_addr);
        for (i = 0; i < 3; i++) begin
            run_cycle(8, 1'b1, "stage change during write");
        end
        run_cycle(8, 1'b0, "stage change during write");
        run_cycle(8, 1'b1, "stage change during write");
        check_value("stage change during write", "restart after write low", 32 * 17,
                    sampled_addr);

        // random stages and write pattern against the model
        for (j = 0; j < 150; j++) begin
            s   = int'($urandom_range(15, 0));
            len = int'($urandom_range(40, 1));
            for (i = 0; i < len; i++) begin
                w = ($urandom_range(99, 0) < 70);
                run_cycle(s, w, "random run");
            end
        end

        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tests
design/fmap_pkg.sv
design/fmap_stage_decode.sv
design/fmap_position_counter.sv
design/fmap_offset_table.sv
design/fmap_addr_gen.sv
design/fmap_write_ctrl.sv
tests/tb_fmap_write_ctrl.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module tb_fmap_write_ctrl \
		--Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "TB FAILED" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "TB PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
